/* include/starfield_settings.svh */
/* screen timing is fixed 640x480 at a 25.175 MHz pixel clock, negative syncs
   layer masks only reach the star field bits, never the brightness byte */
`ifndef STARFIELD_SETTINGS_SVH
`define STARFIELD_SETTINGS_SVH

// horizontal timing, in pixels
`define SF_H_RES     640
`define SF_H_FP      16
`define SF_H_SYNC    96
`define SF_H_BP      48
`define SF_H_TOTAL   (`SF_H_RES + `SF_H_FP + `SF_H_SYNC + `SF_H_BP)    // 800

// vertical timing, in lines
`define SF_V_RES     480
`define SF_V_FP      10
`define SF_V_SYNC    2
`define SF_V_BP      33
`define SF_V_TOTAL   (`SF_V_RES + `SF_V_FP + `SF_V_SYNC + `SF_V_BP)    // 525

`define SF_FRAME_PIX (`SF_H_TOTAL * `SF_V_TOTAL)                        // 420000
`define SF_CORDW     10

// lfsr shape; taps are 1-indexed bit positions
`define SF_LFSR_W      21
`define SF_BRIGHT_W    8    // low byte of the word is brightness
`define SF_LFSR_TAP_HI 21
`define SF_LFSR_TAP_LO 19

// layer defaults, negative inc drifts left
`define SF1_INC   (-1)
`define SF2_INC   (-2)
`define SF3_INC   (-4)
`define SF1_SEED  21'h09A9A9
`define SF2_SEED  21'h0A9A9A
`define SF3_SEED  21'h1FFFFF
`define SF1_MASK  21'h000000
`define SF2_MASK  21'h000000
`define SF3_MASK  21'h0007FF    // denser far layer

`endif

/* run_sim.sh */
#!/bin/sh
# Build the starfield testbench with Verilator and run it.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    -f sources.f \
    --top-module tb_starfields \
    -Mdir obj_dir \
    -o tb_starfields
status=$?
if [ "$status" -ne 0 ]; then
    echo "run_sim.sh: verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/tb_starfields
status=$?
if [ "$status" -ne 0 ]; then
    echo "run_sim.sh: simulation failed with status $status"
    exit "$status"
fi

echo "run_sim.sh: simulation finished cleanly"
exit 0

/* sim/tb_starfields.sv */
/* drives top_starfields through a table of scenarios, one pixel per step
   expected pins come from a reference model of timing, lfsr layers and mixer
   a full frame is 420000 pixels, so a run covers about seven frames */
`timescale 1ns/1ps

`include "starfield_settings.svh"

module tb_starfields
    import starfield_pkg::*;
();

    localparam int FRAME_PIX    = `SF_FRAME_PIX;
    localparam int H_TOTAL      = `SF_H_TOTAL;
    localparam int H_SYNC_START = `SF_H_RES + `SF_H_FP;      // 656
    localparam int H_SYNC_END   = H_SYNC_START + `SF_H_SYNC;  // 752
    localparam int V_SYNC_START = `SF_V_RES + `SF_V_FP;      // 490
    localparam int V_SYNC_END   = V_SYNC_START + `SF_V_SYNC;  // 492
    localparam int WATCHDOG_NS  = 16000000;                  // whole run limit
    localparam int NUM_ROWS     = 3;

    typedef enum logic {CHK_ALL, CHK_SYNC} chk_mode_t;

    // one row of the stimulus table
    typedef struct packed {
        int        rst_cycles;  // reset length, also for a mid-frame pulse
        int        frames;      // frames checked after the last release
        logic      mid_rst;     // pulse reset at an lcg-chosen pixel
        chk_mode_t mode;        // colours too, or syncs only
    } scenario_t;

    logic  clk_pix;
    logic  arst_n;
    logic  vga_hsync;
    logic  vga_vsync;
    grey_t vga_r;
    grey_t vga_g;
    grey_t vga_b;

    // reference model state
    int          pix;            // pixel index the counters hold
    lfsr_word_u  m_lfsr [3];
    int          m_cnt [3];      // steps since last reload
    int          wins [3];       // pixels where each layer won priority
    logic        exp_hs;
    logic        exp_vs;
    grey_t       exp_grey;
    scenario_t   scenarios [NUM_ROWS];
    logic [31:0] lcg_state;

    top_starfields uut (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    always #2 clk_pix = ~clk_pix;   // 4 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // per-layer parameters, layer 1 at index 0
    function automatic logic [`SF_LFSR_W-1:0] seed_of(input int i);
        case (i)
            0:       return `SF1_SEED;
            1:       return `SF2_SEED;
            default: return `SF3_SEED;
        endcase
    endfunction

    function automatic int inc_of(input int i);
        case (i)
            0:       return `SF1_INC;
            1:       return `SF2_INC;
            default: return `SF3_INC;
        endcase
    endfunction

    function automatic logic [`SF_LFSR_W-1:0] mask_of(input int i);
        case (i)
            0:       return `SF1_MASK;
            1:       return `SF2_MASK;
            default: return `SF3_MASK;
        endcase
    endfunction

    task automatic abort_run;
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_sync(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("mismatch t=%0t %s expected=%b actual=%b", $time, name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_grey(input string name, input grey_t expected, input grey_t actual);
        if (actual !== expected) begin
            $display("mismatch t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
            abort_run();
        end
    endtask

    // what the pins and layers hold while arst_n is low
    task automatic reset_model;
        int i;
        pix = 0;
        for (i = 0; i < 3; i++) begin
            m_lfsr[i].raw = seed_of(i);
            m_cnt[i]      = 0;
        end
        exp_hs   = 1'b1;   // syncs idle high
        exp_vs   = 1'b1;
        exp_grey = '0;
    endtask

    // one clock edge out of reset: pins take the current pixel, state moves on
    task automatic advance_model;
        int         sx;
        int         sy;
        int         i;
        logic       de;
        logic       found;
        lfsr_word_u mk;
        sx       = pix % H_TOTAL;
        sy       = pix / H_TOTAL;
        de       = (sx < `SF_H_RES) && (sy < `SF_V_RES);
        exp_hs   = !((sx >= H_SYNC_START) && (sx < H_SYNC_END));
        exp_vs   = !((sy >= V_SYNC_START) && (sy < V_SYNC_END));
        exp_grey = '0;                     // blank or empty sky
        found    = 1'b0;
        for (i = 0; i < 3; i++) begin
            mk.raw = mask_of(i);
            // lowest layer number wins
            if (!found && de && (&(m_lfsr[i].fields.star | mk.fields.star))) begin
                exp_grey = m_lfsr[i].fields.bright[`SF_BRIGHT_W-1 -: 4];
                found    = 1'b1;
                wins[i]  = wins[i] + 1;
            end
        end
        pix = (pix + 1) % FRAME_PIX;
        for (i = 0; i < 3; i++) begin
            if (m_cnt[i] == FRAME_PIX + inc_of(i) - 1) begin
                m_lfsr[i].raw = seed_of(i);  // early restart gives the drift
                m_cnt[i]      = 0;
            end else begin
                // taps at bits 21 and 19, counted from 1
                m_lfsr[i].raw = {m_lfsr[i].raw[`SF_LFSR_W-2:0],
                                 m_lfsr[i].raw[20] ^ m_lfsr[i].raw[18]};
                m_cnt[i]      = m_cnt[i] + 1;
            end
        end
    endtask

    task automatic compare_pins(input chk_mode_t mode);
        check_sync("vga_hsync", exp_hs, vga_hsync);
        check_sync("vga_vsync", exp_vs, vga_vsync);
        if (mode == CHK_ALL || !arst_n) begin
            check_grey("vga_r", exp_grey, vga_r);
            check_grey("vga_g", exp_grey, vga_g);
            check_grey("vga_b", exp_grey, vga_b);
        end
    endtask

    // one pixel: edge, drive reset 1 ns later, check mid-cycle
    task automatic step_pixel(input logic rst_val, input chk_mode_t mode);
        @(posedge clk_pix);
        if (arst_n) begin
            advance_model();
        end
        #1;
        arst_n = rst_val;
        if (!rst_val) begin
            reset_model();                 // async, takes effect at once
        end
        @(negedge clk_pix);
        compare_pins(mode);
    endtask

    task automatic apply_reset(input int cycles, input chk_mode_t mode);
        int n;
        for (n = 0; n < cycles; n++) begin
            step_pixel(1'b0, mode);
        end
        step_pixel(1'b1, mode);            // release, pins still idle
    endtask

    task automatic run_pixels(input int count, input chk_mode_t mode);
        int n;
        for (n = 0; n < count; n++) begin
            step_pixel(1'b1, mode);
        end
    endtask

    // first vsync pulse on the pins, at most one frame away
    task automatic wait_vsync_low(input chk_mode_t mode);
        int n;
        n = 0;
        while (vga_vsync !== 1'b0 && n < FRAME_PIX + 8) begin
            step_pixel(1'b1, mode);
            n = n + 1;
        end
        if (vga_vsync !== 1'b0) begin
            $display("timeout: vga_vsync did not go low within one frame");
            abort_run();
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: simulation ran past its time limit");
        abort_run();
    end

    initial begin
        int r;
        int pick;
        clk_pix   = 1'b0;
        arst_n    = 1'b0;
        lcg_state = 32'h4d57;
        wins[0]   = 0;
        wins[1]   = 0;
        wins[2]   = 0;
        reset_model();

        // three frames for the drift, a mid-frame reset, a syncs-only pass
        scenarios[0] = '{rst_cycles: 10, frames: 3, mid_rst: 1'b0, mode: CHK_ALL};
        scenarios[1] = '{rst_cycles: 6, frames: 1, mid_rst: 1'b1, mode: CHK_ALL};
        scenarios[2] = '{rst_cycles: 4, frames: 1, mid_rst: 1'b0, mode: CHK_SYNC};

        for (r = 0; r < NUM_ROWS; r++) begin
            $display("scenario %0d: reset %0d cycles, %0d frames",
                     r, scenarios[r].rst_cycles, scenarios[r].frames);
            apply_reset(scenarios[r].rst_cycles, scenarios[r].mode);
            if (scenarios[r].mid_rst) begin
                lcg_state = lcg_next(lcg_state);
                // land inside both sync pulses so the reset has to raise them
                pick      = (V_SYNC_START + int'(lcg_state[31])) * H_TOTAL
                            + H_SYNC_START + (int'(lcg_state[30:16]) % `SF_H_SYNC);
                $display("  reset pulse at pixel %0d", pick);
                run_pixels(pick, scenarios[r].mode);
                apply_reset(scenarios[r].rst_cycles, scenarios[r].mode);
            end
            if (scenarios[r].mode == CHK_SYNC) begin
                wait_vsync_low(scenarios[r].mode);
            end
            run_pixels(scenarios[r].frames * FRAME_PIX, scenarios[r].mode);
        end

        // every layer should have won some pixels
        if (wins[0] == 0 || wins[1] == 0 || wins[2] == 0) begin
            $display("a layer never showed a star: %0d %0d %0d", wins[0], wins[1], wins[2]);
            $display("TESTBENCH FAILED");
            $fatal(1, "layer coverage check failed");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

/* sources.f */
+incdir+include
src/starfield_pkg.sv
src/display_if.sv
src/display_timings.sv
src/starfield.sv
src/star_mixer.sv
src/top_starfields.sv
sim/tb_starfields.sv

/* src/display_if.sv */
/* position, syncs and blanking of the pixel stream, all aligned to one pixel
   hsync and vsync are active low; frame pulses once at sx = sy = 0 */
`timescale 1ns/1ps

interface display_if
    import starfield_pkg::*;
();

    cord_t sx;      // column, 0..799
    cord_t sy;      // line, 0..524
    logic  hsync;   // active low
    logic  vsync;   // active low
    logic  de;      // visible area
    logic  frame;   // first pixel of frame

    // timing generator side
    modport src (
        output sx, sy, hsync, vsync, de, frame
    );

    // layers and mixer
    modport snk (
        input sx, sy, hsync, vsync, de, frame
    );

endinterface

/* src/display_timings.sv */
/* free-running 640x480 timing generator, no back-pressure
   syncs and de are decoded from the counters, so they change with sx/sy */
`timescale 1ns/1ps

`include "starfield_settings.svh"

module display_timings
    import starfield_pkg::*;
(
    input  logic clk_pix,
    input  logic arst_n,
    display_if.src disp
);

    // horizontal positions
    localparam int H_RES   = `SF_H_RES;
    localparam int H_SSTA  = `SF_H_RES + `SF_H_FP;   // 656
    localparam int H_SEND  = H_SSTA + `SF_H_SYNC;    // 752, first col after sync
    localparam int H_LAST  = `SF_H_TOTAL - 1;        // 799

    // vertical positions
    localparam int V_RES   = `SF_V_RES;
    localparam int V_SSTA  = `SF_V_RES + `SF_V_FP;   // 490
    localparam int V_SEND  = V_SSTA + `SF_V_SYNC;    // 492
    localparam int V_LAST  = `SF_V_TOTAL - 1;        // 524

    cord_t sx;
    cord_t sy;
    logic  line_end;
    logic  frame_end;

    assign line_end  = (sx == cord_t'(H_LAST));
    assign frame_end = line_end && (sy == cord_t'(V_LAST));

    // column counter
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
        end else if (line_end) begin
            sx <= '0;                      // wrap at 800
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // line counter, steps on the last column
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sy <= '0;
        end else if (frame_end) begin
            sy <= '0;                      // wrap at 525
        end else if (line_end) begin
            sy <= sy + 1'b1;
        end
    end

    // decode from the current position
    always_comb begin
        disp.sx    = sx;
        disp.sy    = sy;
        // sync pulses sit between front and back porch
        disp.hsync = ~((sx >= cord_t'(H_SSTA)) && (sx < cord_t'(H_SEND)));
        disp.vsync = ~((sy >= cord_t'(V_SSTA)) && (sy < cord_t'(V_SEND)));
        disp.de    = (sx < cord_t'(H_RES)) && (sy < cord_t'(V_RES));
        disp.frame = (sx == '0) && (sy == '0);  // one cycle per frame
    end

endmodule

/* src/star_mixer.sv */
/* layer 1 wins over 2, 2 over 3; one register stage to the vga pins
   syncs are delayed with the colour so they stay aligned */
`timescale 1ns/1ps

`include "starfield_settings.svh"

module star_mixer
    import starfield_pkg::*;
(
    input  logic       clk_pix,
    input  logic       arst_n,
    display_if.snk     disp,
    input  logic       sf1_on,
    input  logic       sf2_on,
    input  logic       sf3_on,
    input  lfsr_word_u sf1_star,
    input  lfsr_word_u sf2_star,
    input  lfsr_word_u sf3_star,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output grey_t      vga_r,
    output grey_t      vga_g,
    output grey_t      vga_b
);

    grey_t starlight;   // chosen layer brightness
    grey_t pix;         // after blanking

    // priority pick, top nibble of the brightness byte
    always_comb begin
        if (sf1_on) begin
            starlight = sf1_star.fields.bright[`SF_BRIGHT_W-1 -: 4];
        end else if (sf2_on) begin
            starlight = sf2_star.fields.bright[`SF_BRIGHT_W-1 -: 4];
        end else if (sf3_on) begin
            starlight = sf3_star.fields.bright[`SF_BRIGHT_W-1 -: 4];
        end else begin
            starlight = '0;                // empty sky
        end
        pix = disp.de ? starlight : '0;    // black in blanking
    end

    // output register, syncs idle high in reset
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            vga_hsync <= 1'b1;
            vga_vsync <= 1'b1;
            vga_r     <= '0;
            vga_g     <= '0;
            vga_b     <= '0;
        end else begin
            vga_hsync <= disp.hsync;
            vga_vsync <= disp.vsync;
            vga_r     <= pix;              // grey, all channels alike
            vga_g     <= pix;
            vga_b     <= pix;
        end
    end

endmodule

/* src/starfield.sv */
/* one starfield layer; the lfsr restarts every 420000+INC pixels, so the field
   moves INC pixels per frame. a seed of all zeros locks the lfsr at zero */
`timescale 1ns/1ps

`include "starfield_settings.svh"

module starfield
    import starfield_pkg::*;
#(
    parameter int                    INC  = `SF1_INC,
    parameter logic [`SF_LFSR_W-1:0] SEED = `SF1_SEED,
    parameter logic [`SF_LFSR_W-1:0] MASK = `SF1_MASK
) (
    input  logic       clk_pix,
    input  logic       arst_n,
    display_if.snk     disp,
    output logic       star_on,
    output lfsr_word_u star
);

    // lfsr run length between reloads
    localparam int PERIOD = `SF_FRAME_PIX + INC;
    localparam int CNT_W  = (PERIOD > 2) ? $clog2(PERIOD) : 1;

    // 0-indexed tap bits
    localparam int TAP_HI = `SF_LFSR_TAP_HI - 1;
    localparam int TAP_LO = `SF_LFSR_TAP_LO - 1;

    // mask bits that overlay the star field
    localparam logic [STAR_W-1:0] STAR_MASK = MASK[`SF_LFSR_W-1:`SF_BRIGHT_W];

    logic [CNT_W-1:0] cnt;         // steps since last reload
    lfsr_word_u       lfsr;
    logic             reload;
    logic             fb;

    assign reload = (cnt == CNT_W'(PERIOD - 1));
    assign fb     = lfsr.raw[TAP_HI] ^ lfsr.raw[TAP_LO];  // fibonacci feedback

    // frame-length counter
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (reload) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // one shift per pixel, new bit in at bit 0
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            lfsr.raw <= SEED;
        end else if (reload) begin
            lfsr.raw <= SEED;          // restart a few pixels early or late
        end else begin
            lfsr.raw <= {lfsr.raw[`SF_LFSR_W-2:0], fb};
        end
    end

    // zero latency against disp; blanking is left to the mixer
    always_comb begin
        star    = lfsr;
        star_on = &(lfsr.fields.star | STAR_MASK);
    end

endmodule

/* src/starfield_pkg.sv */
/* shared types for the starfield display
   lfsr_word_u splits the shift state into star field and brightness */
`include "starfield_settings.svh"

package starfield_pkg;

    // screen coordinate, wide enough for 800 columns and 525 lines
    typedef logic [`SF_CORDW-1:0] cord_t;

    // one 4-bit vga colour channel
    typedef logic [3:0] grey_t;

    // width of the star detect part of the lfsr word
    localparam int STAR_W = `SF_LFSR_W - `SF_BRIGHT_W;

    // star view of the lfsr word
    typedef struct packed {
        logic [STAR_W-1:0]       star;      // all ones (after mask) means star
        logic [`SF_BRIGHT_W-1:0] bright;    // top nibble drives the pins
    } lfsr_fields_t;

    // same 21 bits read two ways
    typedef union packed {
        logic [`SF_LFSR_W-1:0] raw;         // shift state
        lfsr_fields_t          fields;
    } lfsr_word_u;

endpackage

/* src/top_starfields.sv */
/* three-layer starfield on a 640x480 vga stream
   clk_pix must already be the pixel clock; arst_n is used as is, no sync */
`timescale 1ns/1ps

`include "starfield_settings.svh"

module top_starfields
    import starfield_pkg::*;
(
    input  logic       clk_pix,
    input  logic       arst_n,
    output logic       vga_hsync,
    output logic       vga_vsync,
    output logic [3:0] vga_r,
    output logic [3:0] vga_g,
    output logic [3:0] vga_b
);

    display_if disp ();

    // layer outputs into the mixer
    logic       sf1_on;
    logic       sf2_on;
    logic       sf3_on;
    lfsr_word_u sf1_star;
    lfsr_word_u sf2_star;
    lfsr_word_u sf3_star;

    // pacing for everything below
    display_timings timings (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp)
    );

    // near layer, slowest drift
    starfield #(
        .INC  (`SF1_INC),
        .SEED (`SF1_SEED),
        .MASK (`SF1_MASK)
    ) sf1 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp),
        .star_on (sf1_on),
        .star    (sf1_star)
    );

    starfield #(
        .INC  (`SF2_INC),
        .SEED (`SF2_SEED),
        .MASK (`SF2_MASK)
    ) sf2 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp),
        .star_on (sf2_on),
        .star    (sf2_star)
    );

    // far layer, masked so it has more stars
    starfield #(
        .INC  (`SF3_INC),
        .SEED (`SF3_SEED),
        .MASK (`SF3_MASK)
    ) sf3 (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .disp    (disp),
        .star_on (sf3_on),
        .star    (sf3_star)
    );

    star_mixer mixer (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .disp      (disp),
        .sf1_on    (sf1_on),
        .sf2_on    (sf2_on),
        .sf3_on    (sf3_on),
        .sf1_star  (sf1_star),
        .sf2_star  (sf2_star),
        .sf3_star  (sf3_star),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

endmodule
